// ==== tests/mmu_walk_patterns.txt ====
// Tag 1 memory word: byte address, 64-bit data
// Tag 2 case: vaddr write user flush sreset hit fault cause paddr
1 00001000 0000000000002001
1 00001008 0000000000003001
1 00002000 8000100580000007
1 00002008 8000300080002003
1 00002010 8000500780004007
1 00003000 9000100790000007
2 00000123 0 0 0 0 0 0 0 80000123
2 00000456 1 1 0 0 1 0 0 80000456
2 00001010 1 1 0 0 0 1 3 00000000
2 00001020 0 1 0 0 0 0 0 80001020
2 00001040 0 0 0 0 1 0 0 80001040
2 00002000 0 1 0 0 0 1 3 00000000
2 00002004 1 0 0 0 0 0 0 80002004
2 00400000 0 0 0 0 0 1 1 00000000
2 00400000 0 0 0 0 0 1 1 00000000
2 00003000 0 0 0 0 0 1 2 00000000
2 00003000 0 0 0 0 0 1 2 00000000
2 00000abc 0 0 1 0 0 0 0 80000abc
2 00004000 0 0 0 0 0 0 0 80004000
2 00005000 0 0 0 0 0 0 0 80005000
2 00800000 0 0 0 0 0 0 0 90000000
2 00801000 0 0 0 0 0 0 0 90001000
2 00004004 0 0 0 0 1 0 0 80004004
2 00000def 0 0 0 0 0 0 0 80000def
2 00005008 0 0 0 1 0 0 0 00000000
2 00005008 0 0 0 0 0 0 0 80005008
2 00801abc 0 0 0 0 0 0 0 90001abc

// ==== sim.f ====
hdl/mmu_pkg.sv
hdl/mem_pkg.sv
hdl/mmu_table_load.sv
hdl/mmu_tlb.sv
hdl/mmu_perm_check.sv
hdl/mmu_walk_ctrl.sv
hdl/mmu_top.sv
tests/tb_mmu_top.sv

// ==== tests/tb_mmu_top.sv ====
module tb_mmu_top;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int MEM_WORDS = 2048;	// Byte addresses 0x0000 to 0x3fff
	localparam int PAT_WORDS = 512;
	localparam logic [31:0] PDT_BASE = 32'h0000_1000;

	logic iCLOCK = 1'b0;
	logic inRESET = 1'b0;
	logic reset_sync = 1'b0;
	logic tr_req = 1'b0;
	logic [31:0] tr_vaddr = '0;
	logic tr_write = 1'b0;
	logic tr_user = 1'b0;
	logic flush = 1'b0;
	logic mem_lock = 1'b0;
	logic mem_valid = 1'b0;
	logic [63:0] mem_data = '0;
	logic tr_busy;
	logic tr_valid;
	logic [31:0] tr_paddr;
	logic tr_fault;
	logic [1:0] tr_cause;
	logic mem_req;
	logic [31:0] mem_addr;

	logic [63:0] pattern_words [PAT_WORDS];
	logic [63:0] mem_model [MEM_WORDS];
	logic [31:0] beat_addr;
	integer seed = 32'h7f83;
	int lock_left = 0;
	int beat_wait = 0;
	int cycle_count = 0;
	int cycle_limit = 100;

	mmu_top #(.TLB_ENTRIES(4)) mmu_top_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iRESET_SYNC(reset_sync),
		.iTR_REQ(tr_req), .iTR_VADDR(tr_vaddr), .iTR_WRITE(tr_write), .iTR_USER(tr_user),
		.oTR_BUSY(tr_busy), .oTR_VALID(tr_valid), .oTR_PADDR(tr_paddr),
		.oTR_FAULT(tr_fault), .oTR_FAULT_CAUSE(tr_cause), .iPDT_BASE(PDT_BASE),
		.iFLUSH(flush), .oMEM_REQ(mem_req), .oMEM_ADDR(mem_addr), .iMEM_LOCK(mem_lock),
		.iMEM_VALID(mem_valid), .iMEM_DATA(mem_data)
	);

	always #4 iCLOCK = ~iCLOCK;

	function automatic void halt_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped at the first error");
	endfunction

	function automatic int random_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [63:0] fill_word(logic [31:0] byte_addr);
		return {~byte_addr, byte_addr ^ 32'h5a5a_5a5a};
	endfunction

	function automatic void compare_field(int idx, string field, logic [31:0] expected,
		logic [31:0] actual);
		assert (expected === actual) else begin
			$display("error: case %0d %s expected %h actual %h", idx, field, expected, actual);
			halt_run();
		end
	endfunction

	always @(posedge iCLOCK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: no translation result within %0d cycles", cycle_limit);
			halt_run();
		end
	end

	// Memory pipe model that arms the lock before the request shows up
	always @(posedge iCLOCK) begin
		mem_valid <= 1'b0;
		if (!inRESET) begin
			lock_left = random_below(4);
			mem_lock <= (lock_left != 0);
			beat_wait = 0;
		end
		else if (beat_wait != 0) begin
			beat_wait = beat_wait - 1;
			if (beat_wait == 0) begin
				mem_valid <= 1'b1;
				mem_data <= mem_model[beat_addr[31:3]];
				lock_left = random_below(4);	// Stall for the next load
				mem_lock <= (lock_left != 0);
			end
		end
		else if (mem_req && mem_lock) begin
			lock_left = lock_left - 1;
			mem_lock <= (lock_left != 0);
		end
		else if (mem_req) begin
			assert (mem_addr[31:3] < MEM_WORDS) else begin
				$display("Table load from address %h lies outside the memory model", mem_addr);
				halt_run();
			end
			beat_addr = mem_addr;
			beat_wait = 1 + random_below(4);
		end
	end

	// Walk is cut by a sync reset once its first memory request is seen
	task automatic cut_walk(input int idx);
		do begin
			@(posedge iCLOCK);
			tr_req <= 1'b0;
		end while (!mem_req);
		reset_sync <= 1'b1;
		@(posedge iCLOCK);
		reset_sync <= 1'b0;
		repeat (30) begin
			@(posedge iCLOCK);
			assert (!tr_valid) else begin
				$display("Case %0d gave a translation result after the sync reset", idx);
				halt_run();
			end
			assert (!tr_busy && !mem_req) else begin
				$display("Case %0d left the MMU active after the sync reset", idx);
				halt_run();
			end
		end
	endtask

	task automatic run_case(input int idx, input int base);
		int cycles;
		while (tr_busy) begin
			@(posedge iCLOCK);
		end
		// Sync reset cases start from an empty TLB so the walk reaches memory
		if (pattern_words[base + 4][0] || pattern_words[base + 5][0]) begin
			flush <= 1'b1;
			@(posedge iCLOCK);
			flush <= 1'b0;
		end
		tr_req <= 1'b1;
		tr_vaddr <= pattern_words[base + 1][31:0];
		tr_write <= pattern_words[base + 2][0];
		tr_user <= pattern_words[base + 3][0];
		if (pattern_words[base + 5][0]) begin
			cut_walk(idx);
		end
		else begin
			cycles = 0;
			do begin
				@(posedge iCLOCK);
				tr_req <= 1'b0;
				cycles++;
				if (cycles > 1) begin
					compare_field(idx, "busy", 32'd1, tr_busy);
				end
			end while (!tr_valid);
			if (pattern_words[base + 6][0]) begin
				compare_field(idx, "hit latency", 32'd2, cycles - 1);
			end
			else begin
				assert (cycles > 3) else begin
					$display("error: case %0d miss latency expected more than 2 actual %0d",
						idx, cycles - 1);
					halt_run();
				end
			end
			compare_field(idx, "fault", pattern_words[base + 7][0], tr_fault);
			compare_field(idx, "cause", pattern_words[base + 8][1:0], tr_cause);
			compare_field(idx, "paddr", pattern_words[base + 9][31:0], tr_paddr);
			@(posedge iCLOCK);
			compare_field(idx, "valid after result", 32'd0, tr_valid);
			compare_field(idx, "busy after result", 32'd0, tr_busy);
		end
	endtask

	initial begin
		int pos;
		int case_count;
		for (int i = 0; i < PAT_WORDS; i++) begin
			pattern_words[i] = '0;
		end
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_model[i] = fill_word(32'(i) << 3);
		end
		$readmemh("tests/mmu_walk_patterns.txt", pattern_words);
		pos = 0;
		case_count = 0;
		while ((pos < PAT_WORDS - 10) && (pattern_words[pos] != 0)) begin
			if (pattern_words[pos] == 1) begin
				mem_model[pattern_words[pos + 1][31:3]] = pattern_words[pos + 2];
				pos += 3;
			end
			else begin
				assert (pattern_words[pos] == 2) else begin
					$display("Unknown record tag at pattern word %0d", pos);
					halt_run();
				end
				case_count++;
				pos += 10;
			end
		end
		assert (case_count > 0) else begin
			$display("No translation cases found in the pattern file");
			halt_run();
		end
		cycle_limit = case_count * 40 + 100;

		repeat (5) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(posedge iCLOCK);
		pos = 0;
		case_count = 0;
		while ((pos < PAT_WORDS - 10) && (pattern_words[pos] != 0)) begin
			if (pattern_words[pos] == 2) begin
				case_count++;
				run_case(case_count, pos);
				pos += 10;
			end
			else begin
				pos += 3;
			end
		end
		@(posedge iCLOCK);
		$display("Test completed successfully");
		$finish;
	end

endmodule

// ==== hdl/mmu_top.sv ====
`default_nettype none

module mmu_top #(
	parameter int TLB_ENTRIES = 4
) (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic iRESET_SYNC,
	input wire logic iTR_REQ,
	input wire logic [31:0] iTR_VADDR,
	input wire logic iTR_WRITE,
	input wire logic iTR_USER,
	output logic oTR_BUSY,
	output logic oTR_VALID,
	output logic [31:0] oTR_PADDR,
	output logic oTR_FAULT,
	output logic [1:0] oTR_FAULT_CAUSE,
	input wire logic [31:0] iPDT_BASE,
	input wire logic iFLUSH,
	output logic oMEM_REQ,
	output logic [mem_pkg::MEM_ADDR_W-1:0] oMEM_ADDR,
	input wire logic iMEM_LOCK,
	input wire logic iMEM_VALID,
	input wire logic [mem_pkg::MEM_DATA_W-1:0] iMEM_DATA
);

	logic [mmu_pkg::VPN_DIR_W+mmu_pkg::VPN_TBL_W-1:0] lk_vpn;
	logic lk_hit;
	mmu_pkg::entry_u lk_entry;
	logic fill;
	logic [mmu_pkg::VPN_DIR_W+mmu_pkg::VPN_TBL_W-1:0] fill_vpn;
	mmu_pkg::entry_u fill_entry;
	logic ld_req;
	logic [mem_pkg::MEM_ADDR_W-1:0] ld_addr;
	logic ld_busy;
	logic done_valid;
	mmu_pkg::entry_u done_data;
	mmu_pkg::entry_u chk_entry;
	logic [mmu_pkg::PAGE_OFS_W-1:0] chk_offset;
	logic chk_write;
	logic chk_user;
	logic [31:0] chk_paddr;
	logic chk_fault;
	logic [1:0] chk_cause;

	mmu_walk_ctrl walk_ctrl_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iRESET_SYNC(iRESET_SYNC),
		.iTR_REQ(iTR_REQ), .iTR_VADDR(iTR_VADDR), .iTR_WRITE(iTR_WRITE), .iTR_USER(iTR_USER),
		.oTR_BUSY(oTR_BUSY), .oTR_VALID(oTR_VALID), .oTR_PADDR(oTR_PADDR),
		.oTR_FAULT(oTR_FAULT), .oTR_FAULT_CAUSE(oTR_FAULT_CAUSE), .iPDT_BASE(iPDT_BASE),
		.oLK_VPN(lk_vpn), .iLK_HIT(lk_hit), .iLK_ENTRY(lk_entry),
		.oFILL(fill), .oFILL_VPN(fill_vpn), .oFILL_ENTRY(fill_entry),
		.oLD_REQ(ld_req), .oLD_ADDR(ld_addr), .iLD_BUSY(ld_busy),
		.iDONE_VALID(done_valid), .iDONE_DATA(done_data),
		.oCHK_ENTRY(chk_entry), .oCHK_OFFSET(chk_offset), .oCHK_WRITE(chk_write),
		.oCHK_USER(chk_user), .iCHK_PADDR(chk_paddr), .iCHK_FAULT(chk_fault),
		.iCHK_CAUSE(chk_cause)
	);

	mmu_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iRESET_SYNC(iRESET_SYNC), .iFLUSH(iFLUSH),
		.iLK_VPN(lk_vpn), .oLK_HIT(lk_hit), .oLK_ENTRY(lk_entry),
		.iFILL(fill), .iFILL_VPN(fill_vpn), .iFILL_ENTRY(fill_entry)
	);

	mmu_table_load table_load_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .iRESET_SYNC(iRESET_SYNC),
		.iLD_REQ(ld_req), .iLD_ADDR(ld_addr), .oLD_BUSY(ld_busy),
		.oMEM_REQ(oMEM_REQ), .iMEM_LOCK(iMEM_LOCK), .oMEM_ADDR(oMEM_ADDR),
		.iMEM_VALID(iMEM_VALID), .iMEM_DATA(iMEM_DATA),
		.oDONE_VALID(done_valid), .oDONE_DATA(done_data)
	);

	mmu_perm_check perm_check_inst (
		.iENTRY(chk_entry), .iOFFSET(chk_offset), .iWRITE(chk_write), .iUSER(chk_user),
		.oPADDR(chk_paddr), .oFAULT(chk_fault), .oFAULT_CAUSE(chk_cause)
	);

endmodule

`default_nettype wire

// ==== hdl/mmu_walk_ctrl.sv ====
`default_nettype none

module mmu_walk_ctrl (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic iRESET_SYNC,
	input wire logic iTR_REQ,
	input wire logic [31:0] iTR_VADDR,
	input wire logic iTR_WRITE,
	input wire logic iTR_USER,
	output logic oTR_BUSY,
	output logic oTR_VALID,
	output logic [31:0] oTR_PADDR,
	output logic oTR_FAULT,
	output logic [1:0] oTR_FAULT_CAUSE,
	input wire logic [31:0] iPDT_BASE,
	output logic [mmu_pkg::VPN_DIR_W+mmu_pkg::VPN_TBL_W-1:0] oLK_VPN,
	input wire logic iLK_HIT,
	input wire mmu_pkg::entry_u iLK_ENTRY,
	output logic oFILL,
	output logic [mmu_pkg::VPN_DIR_W+mmu_pkg::VPN_TBL_W-1:0] oFILL_VPN,
	output mmu_pkg::entry_u oFILL_ENTRY,
	output logic oLD_REQ,
	output logic [mem_pkg::MEM_ADDR_W-1:0] oLD_ADDR,
	input wire logic iLD_BUSY,
	input wire logic iDONE_VALID,
	input wire mmu_pkg::entry_u iDONE_DATA,
	output mmu_pkg::entry_u oCHK_ENTRY,
	output logic [mmu_pkg::PAGE_OFS_W-1:0] oCHK_OFFSET,
	output logic oCHK_WRITE,
	output logic oCHK_USER,
	input wire logic [31:0] iCHK_PADDR,
	input wire logic iCHK_FAULT,
	input wire logic [1:0] iCHK_CAUSE
);

	localparam int OFS_W = mmu_pkg::PAGE_OFS_W;
	localparam int DIR_W = mmu_pkg::VPN_DIR_W;
	localparam int TBL_W = mmu_pkg::VPN_TBL_W;

	localparam logic [2:0] st_idle = 3'd0;
	localparam logic [2:0] st_lookup = 3'd1;
	localparam logic [2:0] st_dir = 3'd2;
	localparam logic [2:0] st_tbl = 3'd3;
	localparam logic [2:0] st_result = 3'd4;

	logic [2:0] b_state;
	logic b_issued;	// Load strobe given for this level
	logic b_fill_ok;
	logic [31:0] b_vaddr;
	logic b_write;
	logic b_user;
	mmu_pkg::entry_u b_entry;	// Holds the PDE and later the PTE
	logic [31:0] b_paddr;
	logic b_fault;
	logic [1:0] b_cause;
	logic [DIR_W-1:0] dir_idx;
	logic [TBL_W-1:0] tbl_idx;
	logic [31:0] pde_addr;
	logic [31:0] pte_addr;
	logic result_load;
	logic pde_fault;

	assign dir_idx = b_vaddr[31 -: DIR_W];
	assign tbl_idx = b_vaddr[OFS_W +: TBL_W];
	assign pde_addr = iPDT_BASE + {{(30 - DIR_W){1'b0}}, dir_idx, 2'b00};
	assign pte_addr = {b_entry.pde.tbl_base, {OFS_W{1'b0}}} +
		{{(30 - TBL_W){1'b0}}, tbl_idx, 2'b00};

	assign result_load = ((b_state == st_lookup) && iLK_HIT) ||
		((b_state == st_tbl) && iDONE_VALID);
	assign pde_fault = (b_state == st_dir) && iDONE_VALID && !iDONE_DATA.pde.present;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= st_idle;
			b_issued <= 1'b0;
			b_fill_ok <= 1'b0;
		end
		else if (iRESET_SYNC) begin
			b_state <= st_idle;
			b_issued <= 1'b0;
			b_fill_ok <= 1'b0;
		end
		else begin
			if (oLD_REQ) begin
				b_issued <= 1'b1;
			end
			case (b_state)
				st_idle: begin
					if (iTR_REQ) begin
						b_state <= st_lookup;
					end
				end
				st_lookup: begin
					b_state <= iLK_HIT ? st_result : st_dir;
					b_fill_ok <= 1'b0;
					b_issued <= 1'b0;
				end
				st_dir: begin
					if (iDONE_VALID) begin
						b_issued <= 1'b0;
						b_state <= pde_fault ? st_result : st_tbl;
					end
				end
				st_tbl: begin
					if (iDONE_VALID) begin
						b_issued <= 1'b0;
						b_state <= st_result;
						b_fill_ok <= !iCHK_FAULT;	// Faulting entries stay out of the TLB
					end
				end
				default: begin
					b_state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if ((b_state == st_idle) && iTR_REQ) begin
			b_vaddr <= iTR_VADDR;
			b_write <= iTR_WRITE;
			b_user <= iTR_USER;
		end
		if (iDONE_VALID) begin
			b_entry <= iDONE_DATA;
		end
		if (result_load) begin
			b_fault <= iCHK_FAULT;
			b_cause <= iCHK_CAUSE;
			b_paddr <= iCHK_FAULT ? 32'h0 : iCHK_PADDR;
		end
		else if (pde_fault) begin
			b_fault <= 1'b1;
			b_cause <= mmu_pkg::FAULT_PDE_NP;
			b_paddr <= 32'h0;
		end
	end

	assign oTR_BUSY = (b_state != st_idle);
	assign oTR_VALID = (b_state == st_result);
	assign oTR_PADDR = b_paddr;
	assign oTR_FAULT = b_fault;
	assign oTR_FAULT_CAUSE = b_cause;

	assign oLK_VPN = b_vaddr[31:OFS_W];
	assign oFILL = (b_state == st_result) && b_fill_ok;
	assign oFILL_VPN = b_vaddr[31:OFS_W];
	assign oFILL_ENTRY = b_entry;

	assign oLD_REQ = ((b_state == st_dir) || (b_state == st_tbl)) && !b_issued && !iLD_BUSY;
	assign oLD_ADDR = (b_state == st_tbl) ? pte_addr : pde_addr;

	// Hit path checks the TLB word and walk path the fresh PTE
	assign oCHK_ENTRY = (b_state == st_tbl) ? iDONE_DATA : iLK_ENTRY;
	assign oCHK_OFFSET = b_vaddr[OFS_W-1:0];
	assign oCHK_WRITE = b_write;
	assign oCHK_USER = b_user;

endmodule

`default_nettype wire

// ==== hdl/mmu_perm_check.sv ====
`default_nettype none

module mmu_perm_check (
	input wire mmu_pkg::entry_u iENTRY,
	input wire logic [mmu_pkg::PAGE_OFS_W-1:0] iOFFSET,
	input wire logic iWRITE,
	input wire logic iUSER,
	output logic [31:0] oPADDR,
	output logic oFAULT,
	output logic [1:0] oFAULT_CAUSE
);

	logic write_deny;
	logic user_deny;

	assign write_deny = iWRITE && !iENTRY.pte.write;
	assign user_deny = iUSER && !iENTRY.pte.user;

	always_comb begin
		if (!iENTRY.pte.present) begin
			oFAULT_CAUSE = mmu_pkg::FAULT_PTE_NP;
		end
		else if (write_deny || user_deny) begin
			oFAULT_CAUSE = mmu_pkg::FAULT_PERM;
		end
		else begin
			oFAULT_CAUSE = mmu_pkg::FAULT_NONE;
		end
	end

	assign oFAULT = (oFAULT_CAUSE != mmu_pkg::FAULT_NONE);
	assign oPADDR = {iENTRY.pte.frame, iOFFSET};	// Valid only without fault

endmodule

`default_nettype wire

// ==== hdl/mmu_tlb.sv ====
`default_nettype none

module mmu_tlb #(
	parameter int TLB_ENTRIES = 4
) (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic iRESET_SYNC,
	input wire logic iFLUSH,
	input wire logic [mmu_pkg::VPN_DIR_W+mmu_pkg::VPN_TBL_W-1:0] iLK_VPN,
	output logic oLK_HIT,
	output mmu_pkg::entry_u oLK_ENTRY,
	input wire logic iFILL,
	input wire logic [mmu_pkg::VPN_DIR_W+mmu_pkg::VPN_TBL_W-1:0] iFILL_VPN,
	input wire mmu_pkg::entry_u iFILL_ENTRY
);

	localparam int PTR_W = $clog2(TLB_ENTRIES);
	localparam int VPN_W = mmu_pkg::VPN_DIR_W + mmu_pkg::VPN_TBL_W;

	logic [TLB_ENTRIES-1:0] b_valid;
	logic [VPN_W-1:0] b_tag [TLB_ENTRIES];
	mmu_pkg::entry_u b_data [TLB_ENTRIES];
	logic [PTR_W-1:0] b_fill_ptr;	// Next slot to replace

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_valid <= '0;
			b_fill_ptr <= '0;
		end
		else if (iRESET_SYNC || iFLUSH) begin
			b_valid <= '0;
			b_fill_ptr <= '0;
		end
		else if (iFILL) begin
			b_valid[b_fill_ptr] <= 1'b1;
			if (b_fill_ptr == PTR_W'(TLB_ENTRIES - 1)) begin
				b_fill_ptr <= '0;
			end
			else begin
				b_fill_ptr <= b_fill_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (iFILL) begin
			b_tag[b_fill_ptr] <= iFILL_VPN;
			b_data[b_fill_ptr] <= iFILL_ENTRY;
		end
	end

	// Parallel compare where the lowest slot wins
	always_comb begin
		oLK_HIT = 1'b0;
		oLK_ENTRY = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (b_valid[i] && (b_tag[i] == iLK_VPN)) begin
				oLK_HIT = 1'b1;
				oLK_ENTRY = b_data[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/mmu_table_load.sv ====
`default_nettype none

module mmu_table_load (
	input wire logic iCLOCK,
	input wire logic inRESET,
	input wire logic iRESET_SYNC,
	input wire logic iLD_REQ,
	input wire logic [mem_pkg::MEM_ADDR_W-1:0] iLD_ADDR,
	output logic oLD_BUSY,
	output logic oMEM_REQ,
	input wire logic iMEM_LOCK,
	output logic [mem_pkg::MEM_ADDR_W-1:0] oMEM_ADDR,
	input wire logic iMEM_VALID,
	input wire logic [mem_pkg::MEM_DATA_W-1:0] iMEM_DATA,
	output logic oDONE_VALID,
	output logic [mem_pkg::MEM_DATA_W/2-1:0] oDONE_DATA
);

	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_req = 2'd1;	// Held under lock
	localparam logic [1:0] st_wait = 2'd2;

	logic [1:0] b_state;
	logic [mem_pkg::MEM_ADDR_W-1:0] b_req_addr;
	logic b_drop;	// Beat of an abandoned load still due
	logic latch_condition;
	logic beat_due;

	assign latch_condition = iLD_REQ && (b_state == st_idle) && !b_drop;

	// A beat that is in flight when the sync reset hits must be swallowed later
	assign beat_due = ((b_drop || (b_state == st_wait)) && !iMEM_VALID) ||
		(((b_state == st_req) || latch_condition) && !iMEM_LOCK);

	always_ff @(posedge iCLOCK) begin
		if (latch_condition) begin
			b_req_addr <= iLD_ADDR;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			b_state <= st_idle;
			b_drop <= 1'b0;
		end
		else if (iRESET_SYNC) begin
			b_state <= st_idle;
			b_drop <= beat_due;
		end
		else begin
			if (iMEM_VALID) begin
				b_drop <= 1'b0;
			end
			case (b_state)
				st_idle: begin
					if (latch_condition) begin
						b_state <= iMEM_LOCK ? st_req : st_wait;
					end
				end
				st_req: begin
					if (!iMEM_LOCK) begin
						b_state <= st_wait;
					end
				end
				st_wait: begin
					if (iMEM_VALID) begin
						b_state <= st_idle;
					end
				end
				default: begin
					b_state <= st_idle;
				end
			endcase
		end
	end

	assign oLD_BUSY = (b_state != st_idle) || b_drop;
	assign oMEM_REQ = (b_state == st_req) || latch_condition;
	assign oMEM_ADDR = (b_state == st_req) ? b_req_addr : iLD_ADDR;	// Direct issue when idle
	assign oDONE_VALID = (b_state == st_wait) && iMEM_VALID;
	assign oDONE_DATA = b_req_addr[mem_pkg::ENTRY_SEL_BIT] ?
		iMEM_DATA[mem_pkg::MEM_DATA_W-1 -: mem_pkg::MEM_DATA_W/2] :
		iMEM_DATA[mem_pkg::MEM_DATA_W/2-1:0];

endmodule

`default_nettype wire

// ==== hdl/mem_pkg.sv ====
package mem_pkg;

	localparam int MEM_ADDR_W = 32;
	localparam int MEM_DATA_W = 64;

	// Picks the 32-bit half of a 64-bit beat
	localparam int ENTRY_SEL_BIT = 2;

endpackage

// ==== hdl/mmu_pkg.sv ====
package mmu_pkg;

	localparam int VPN_DIR_W = 10;	// Directory index, vaddr[31:22]
	localparam int VPN_TBL_W = 10;	// Table index, vaddr[21:12]
	localparam int PAGE_OFS_W = 12;

	localparam logic [1:0] FAULT_NONE = 2'd0;
	localparam logic [1:0] FAULT_PDE_NP = 2'd1;
	localparam logic [1:0] FAULT_PTE_NP = 2'd2;
	localparam logic [1:0] FAULT_PERM = 2'd3;

	typedef struct packed {
		logic [19:0] tbl_base;	// Page table frame
		logic [10:0] rsvd;
		logic present;
	} pde_t;

	typedef struct packed {
		logic [19:0] frame;
		logic [8:0] rsvd;
		logic user;
		logic write;
		logic present;
	} pte_t;

	typedef union packed {
		pde_t pde;
		pte_t pte;
	} entry_u;

endpackage
